//--- design/cachePkg.sv
`default_nettype none

package cachePkg;

   // the byte address splits into tag, set index and byte offset
   localparam int addrWidth = 16;
   localparam int dataWidth = 16;
   localparam int tagWidth = 6;
   localparam int setWidth = 6;
   localparam int offsetWidth = 4;

   // words are 16 bits, so the low offset bit only selects a byte
   localparam int wordIndexWidth = 3;
   localparam int wordsPerBlock = 8;
   localparam int numSets = 64;

   // one metadata byte per set and way
   // bits 5..0 hold the tag
   localparam int metaWidth = 8;
   localparam int metaValidBit = 6;

   // only way 0's copy of this bit is meaningful
   // it names the way to evict next
   localparam int metaLruBit = 7;

   // controller states
   localparam int ctrlStateWidth = 2;
   localparam logic [1:0] ctrlIdle = 2'd0;
   localparam logic [1:0] ctrlLookup = 2'd1;
   localparam logic [1:0] ctrlFill = 2'd2;

   // fill sequencer states
   localparam logic fillIdle = 1'b0;
   localparam logic fillWait = 1'b1;

endpackage

`default_nettype wire

//--- design/metaDataArray.sv
`timescale 1ns/10ps
`default_nettype none

module metaDataArray (
   input  logic                               clk,
   input  logic                               rstN,
   input  logic [cachePkg::setWidth-1:0]      setIndex,
   input  logic                               write,
   input  logic [cachePkg::metaWidth-1:0]     dataIn,
   output logic [cachePkg::metaWidth-1:0]     dataOut
);

   // one metadata byte per set for a single way
   logic [cachePkg::metaWidth-1:0] entries [0:cachePkg::numSets-1];

   // every entry is cleared in reset
   // this drops all valid bits and points the LRU at way 0
   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < cachePkg::numSets; i++) begin
            entries[i] <= '0;
         end
      end else if (write) begin
         // the controller writes a whole byte at a time
         entries[setIndex] <= dataIn;
      end
   end

   // the read is combinational so tag compare happens in the lookup cycle
   // a write in the same cycle shows up on the following cycle
   assign dataOut = entries[setIndex];

endmodule

`default_nettype wire

//--- design/dataArray.sv
`timescale 1ns/10ps
`default_nettype none

module dataArray (
   input  logic                                  clk,
   input  logic [cachePkg::setWidth:0]           blockIndex,
   input  logic [cachePkg::wordIndexWidth-1:0]   wordIndex,
   input  logic                                  write,
   input  logic [cachePkg::dataWidth-1:0]        dataIn,
   output logic [cachePkg::dataWidth-1:0]        dataOut
);

   // blocks are laid out as set index followed by way
   // so the two ways of one set sit next to each other
   logic [cachePkg::dataWidth-1:0] words [0:2*cachePkg::numSets*cachePkg::wordsPerBlock-1];

   // flat word address inside the store
   logic [cachePkg::setWidth+cachePkg::wordIndexWidth:0] wordAddr;

   assign wordAddr = {blockIndex, wordIndex};

   // one word is stored on the clock edge when write is high
   always_ff @(posedge clk) begin
      if (write) begin
         words[wordAddr] <= dataIn;
      end
   end

   // combinational read so a hit answers without an extra cycle
   assign dataOut = words[wordAddr];

endmodule

`default_nettype wire

//--- design/cacheFillFsm.sv
`timescale 1ns/10ps
`default_nettype none

module cacheFillFsm (
   input  logic                                  clk,
   input  logic                                  rstN,
   input  logic                                  fillStart,
   input  logic [cachePkg::addrWidth-1:0]        fillBlockAddr,
   input  logic                                  memRespValid,
   input  logic [cachePkg::dataWidth-1:0]        memRdata,
   output logic                                  memRead,
   output logic [cachePkg::addrWidth-1:0]        memReadAddr,
   output logic                                  fillWordValid,
   output logic [cachePkg::wordIndexWidth-1:0]   fillWordIndex,
   output logic [cachePkg::dataWidth-1:0]        fillWordData,
   output logic                                  fillDone
);

   // idle or waiting for the answer to the read in flight
   logic state;

   // index of the word whose read is outstanding
   logic [cachePkg::wordIndexWidth-1:0] wordCount;

   // block base captured at fillStart
   // only the tag and set bits are kept since the offset is rebuilt per word
   logic [cachePkg::addrWidth-cachePkg::offsetWidth-1:0] blockBase;

   // high when the answer in this cycle belongs to the last word
   logic lastWord;

   assign lastWord = (wordCount == cachePkg::wordIndexWidth'(cachePkg::wordsPerBlock - 1));

   // control state and the read strobe
   always_ff @(posedge clk) begin
      if (!rstN) begin
         state <= cachePkg::fillIdle;
         wordCount <= '0;
         memRead <= 1'b0;
      end else begin
         // memRead is a single cycle strobe
         memRead <= 1'b0;
         case (state)
            cachePkg::fillIdle: begin
               if (fillStart) begin
                  // first read goes out one cycle after the start strobe
                  state <= cachePkg::fillWait;
                  wordCount <= '0;
                  memRead <= 1'b1;
               end
            end
            cachePkg::fillWait: begin
               if (memRespValid) begin
                  if (lastWord) begin
                     state <= cachePkg::fillIdle;
                  end else begin
                     // next word is requested one cycle after this answer
                     wordCount <= wordCount + 1'b1;
                     memRead <= 1'b1;
                  end
               end
            end
            default: begin
               state <= cachePkg::fillIdle;
            end
         endcase
      end
   end

   // the block base is taken when a fill starts from idle
   always_ff @(posedge clk) begin
      if (state == cachePkg::fillIdle && fillStart) begin
         blockBase <= fillBlockAddr[cachePkg::addrWidth-1:cachePkg::offsetWidth];
      end
   end

   // word aligned byte address of the outstanding read
   assign memReadAddr = {blockBase, wordCount, 1'b0};

   // answers are forwarded in the cycle they arrive
   // a stray answer while idle is ignored
   assign fillWordValid = (state == cachePkg::fillWait) && memRespValid;
   assign fillWordIndex = wordCount;
   assign fillWordData = memRdata;

   // done comes together with the eighth word
   assign fillDone = fillWordValid && lastWord;

endmodule

`default_nettype wire

//--- design/cacheController.sv
`timescale 1ns/10ps
`default_nettype none

module cacheController (
   input  logic                                  clk,
   input  logic                                  rstN,
   input  logic                                  reqValid,
   input  logic                                  reqWrite,
   input  logic [cachePkg::addrWidth-1:0]        reqAddr,
   input  logic [cachePkg::dataWidth-1:0]        reqWdata,
   output logic                                  respValid,
   output logic [cachePkg::dataWidth-1:0]        respRdata,
   output logic                                  busy,
   output logic                                  memWrite,
   output logic [cachePkg::addrWidth-1:0]        memWriteAddr,
   output logic [cachePkg::dataWidth-1:0]        memWdata,
   output logic                                  fillStart,
   output logic [cachePkg::addrWidth-1:0]        fillBlockAddr,
   input  logic                                  fillWordValid,
   input  logic [cachePkg::wordIndexWidth-1:0]   fillWordIndex,
   input  logic [cachePkg::dataWidth-1:0]        fillWordData,
   input  logic                                  fillDone,
   output logic [cachePkg::setWidth-1:0]         setIndex,
   output logic                                  meta0Write,
   output logic                                  meta1Write,
   output logic [cachePkg::metaWidth-1:0]        metaDataIn0,
   output logic [cachePkg::metaWidth-1:0]        metaDataIn1,
   input  logic [cachePkg::metaWidth-1:0]        meta0Out,
   input  logic [cachePkg::metaWidth-1:0]        meta1Out,
   output logic [cachePkg::setWidth:0]           dataBlockIndex,
   output logic [cachePkg::wordIndexWidth-1:0]   dataWordIndex,
   output logic                                  dataWrite,
   output logic [cachePkg::dataWidth-1:0]        dataIn,
   input  logic [cachePkg::dataWidth-1:0]        dataOut
);

   logic [cachePkg::ctrlStateWidth-1:0] state;

   // registered request
   logic                           reqWriteQ;
   logic [cachePkg::addrWidth-1:0] reqAddrQ;
   logic [cachePkg::dataWidth-1:0] reqWdataQ;

   // address fields of the registered request
   logic [cachePkg::tagWidth-1:0]       tag;
   logic [cachePkg::wordIndexWidth-1:0] wordIndex;

   logic hit0;
   logic hit1;
   logic hit;
   logic selWay;
   logic victimWay;
   logic blockWay;

   assign tag = reqAddrQ[cachePkg::addrWidth-1 -: cachePkg::tagWidth];
   assign setIndex = reqAddrQ[cachePkg::offsetWidth +: cachePkg::setWidth];
   assign wordIndex = reqAddrQ[1 +: cachePkg::wordIndexWidth];

   // a way hits when its entry is valid and the stored tag matches
   assign hit0 = meta0Out[cachePkg::metaValidBit] && (meta0Out[cachePkg::tagWidth-1:0] == tag);
   assign hit1 = meta1Out[cachePkg::metaValidBit] && (meta1Out[cachePkg::tagWidth-1:0] == tag);
   assign hit = hit0 || hit1;

   // the hit way first and otherwise the way that way 0's LRU bit names
   assign selWay = hit0 ? 1'b0 : (hit1 ? 1'b1 : meta0Out[cachePkg::metaLruBit]);

   // busy covers the lookup, any fill and the response cycle
   assign busy = (state != cachePkg::ctrlIdle) || respValid;

   // write-through path takes the word aligned request address
   assign memWriteAddr = {reqAddrQ[cachePkg::addrWidth-1:1], 1'b0};
   assign memWdata = reqWdataQ;

   // fills always start at the block base
   assign fillBlockAddr = {reqAddrQ[cachePkg::addrWidth-1:cachePkg::offsetWidth],
                           {cachePkg::offsetWidth{1'b0}}};

   // during a fill the victim stays fixed while the metadata is still old
   assign blockWay = (state == cachePkg::ctrlFill) ? victimWay : selWay;
   assign dataBlockIndex = {setIndex, blockWay};

   // control state and the response and memory strobes
   always_ff @(posedge clk) begin
      if (!rstN) begin
         state <= cachePkg::ctrlIdle;
         respValid <= 1'b0;
         memWrite <= 1'b0;
         fillStart <= 1'b0;
      end else begin
         respValid <= 1'b0;
         memWrite <= 1'b0;
         fillStart <= 1'b0;
         case (state)
            cachePkg::ctrlIdle: begin
               if (reqValid) begin
                  state <= cachePkg::ctrlLookup;
               end
            end
            cachePkg::ctrlLookup: begin
               // writes never allocate so a write miss answers like a hit
               if (hit || reqWriteQ) begin
                  respValid <= 1'b1;
                  memWrite <= reqWriteQ;
                  state <= cachePkg::ctrlIdle;
               end else begin
                  fillStart <= 1'b1;
                  state <= cachePkg::ctrlFill;
               end
            end
            cachePkg::ctrlFill: begin
               // after the fill the lookup runs again and now hits
               if (fillDone) begin
                  state <= cachePkg::ctrlLookup;
               end
            end
            default: begin
               state <= cachePkg::ctrlIdle;
            end
         endcase
      end
   end

   // request and response payload
   always_ff @(posedge clk) begin
      if (state == cachePkg::ctrlIdle && reqValid) begin
         reqWriteQ <= reqWrite;
         reqAddrQ <= reqAddr;
         reqWdataQ <= reqWdata;
      end
      if (state == cachePkg::ctrlLookup) begin
         // read data is taken in the lookup cycle and held for the response
         respRdata <= dataOut;
         victimWay <= selWay;
      end
   end

   // array writes
   always_comb begin
      meta0Write = 1'b0;
      meta1Write = 1'b0;
      metaDataIn0 = meta0Out;
      metaDataIn1 = meta1Out;
      dataWrite = 1'b0;
      dataIn = reqWdataQ;
      dataWordIndex = wordIndex;
      case (state)
         cachePkg::ctrlLookup: begin
            if (hit) begin
               // LRU now points at the way not just used
               meta0Write = 1'b1;
               metaDataIn0[cachePkg::metaLruBit] = ~selWay;
               dataWrite = reqWriteQ;
            end
         end
         cachePkg::ctrlFill: begin
            dataWordIndex = fillWordIndex;
            dataIn = fillWordData;
            dataWrite = fillWordValid;
            if (fillDone) begin
               // mark the victim valid with the new tag
               // way 0 keeps its LRU bit until the lookup that follows
               if (victimWay) begin
                  meta1Write = 1'b1;
                  metaDataIn1 = '0;
                  metaDataIn1[cachePkg::metaValidBit] = 1'b1;
                  metaDataIn1[cachePkg::tagWidth-1:0] = tag;
               end else begin
                  meta0Write = 1'b1;
                  metaDataIn0[cachePkg::metaValidBit] = 1'b1;
                  metaDataIn0[cachePkg::tagWidth-1:0] = tag;
               end
            end
         end
         default: begin
            dataWrite = 1'b0;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- design/cacheTop.sv
`timescale 1ns/10ps
`default_nettype none

module cacheTop (
   input  logic                             clk,
   input  logic                             rstN,
   input  logic                             reqValid,
   input  logic                             reqWrite,
   input  logic [cachePkg::addrWidth-1:0]   reqAddr,
   input  logic [cachePkg::dataWidth-1:0]   reqWdata,
   output logic                             respValid,
   output logic [cachePkg::dataWidth-1:0]   respRdata,
   output logic                             busy,
   output logic                             memRead,
   output logic                             memWrite,
   output logic [cachePkg::addrWidth-1:0]   memAddr,
   output logic [cachePkg::dataWidth-1:0]   memWdata,
   input  logic                             memRespValid,
   input  logic [cachePkg::dataWidth-1:0]   memRdata
);

   logic [cachePkg::addrWidth-1:0]      memReadAddr;
   logic [cachePkg::addrWidth-1:0]      memWriteAddr;
   logic                                fillStart;
   logic [cachePkg::addrWidth-1:0]      fillBlockAddr;
   logic                                fillWordValid;
   logic [cachePkg::wordIndexWidth-1:0] fillWordIndex;
   logic [cachePkg::dataWidth-1:0]      fillWordData;
   logic                                fillDone;
   logic [cachePkg::setWidth-1:0]       setIndex;
   logic                                meta0Write;
   logic                                meta1Write;
   logic [cachePkg::metaWidth-1:0]      metaDataIn0;
   logic [cachePkg::metaWidth-1:0]      metaDataIn1;
   logic [cachePkg::metaWidth-1:0]      meta0Out;
   logic [cachePkg::metaWidth-1:0]      meta1Out;
   logic [cachePkg::setWidth:0]         dataBlockIndex;
   logic [cachePkg::wordIndexWidth-1:0] dataWordIndex;
   logic                                dataWrite;
   logic [cachePkg::dataWidth-1:0]      dataIn;
   logic [cachePkg::dataWidth-1:0]      dataOut;

   // reads and writes never overlap so one address bus is shared
   assign memAddr = memRead ? memReadAddr : memWriteAddr;

   cacheController i_ctrl (
      .clk(clk), .rstN(rstN),
      .reqValid(reqValid), .reqWrite(reqWrite), .reqAddr(reqAddr), .reqWdata(reqWdata),
      .respValid(respValid), .respRdata(respRdata), .busy(busy),
      .memWrite(memWrite), .memWriteAddr(memWriteAddr), .memWdata(memWdata),
      .fillStart(fillStart), .fillBlockAddr(fillBlockAddr),
      .fillWordValid(fillWordValid), .fillWordIndex(fillWordIndex),
      .fillWordData(fillWordData), .fillDone(fillDone),
      .setIndex(setIndex), .meta0Write(meta0Write), .meta1Write(meta1Write),
      .metaDataIn0(metaDataIn0), .metaDataIn1(metaDataIn1),
      .meta0Out(meta0Out), .meta1Out(meta1Out),
      .dataBlockIndex(dataBlockIndex), .dataWordIndex(dataWordIndex),
      .dataWrite(dataWrite), .dataIn(dataIn), .dataOut(dataOut)
   );

   cacheFillFsm i_fill (
      .clk(clk), .rstN(rstN),
      .fillStart(fillStart), .fillBlockAddr(fillBlockAddr),
      .memRespValid(memRespValid), .memRdata(memRdata),
      .memRead(memRead), .memReadAddr(memReadAddr),
      .fillWordValid(fillWordValid), .fillWordIndex(fillWordIndex),
      .fillWordData(fillWordData), .fillDone(fillDone)
   );

   // way 0 also carries the LRU bit for the set
   metaDataArray i_meta0 (
      .clk(clk), .rstN(rstN), .setIndex(setIndex),
      .write(meta0Write), .dataIn(metaDataIn0), .dataOut(meta0Out)
   );

   metaDataArray i_meta1 (
      .clk(clk), .rstN(rstN), .setIndex(setIndex),
      .write(meta1Write), .dataIn(metaDataIn1), .dataOut(meta1Out)
   );

   dataArray i_data (
      .clk(clk), .blockIndex(dataBlockIndex), .wordIndex(dataWordIndex),
      .write(dataWrite), .dataIn(dataIn), .dataOut(dataOut)
   );

endmodule

`default_nettype wire

//--- testbench/tbMemory.sv
`timescale 1ns/10ps
`default_nettype none

module tbMemory (
   input  logic                             clk,
   input  logic                             memRead,
   input  logic                             memWrite,
   input  logic [cachePkg::addrWidth-1:0]   memAddr,
   input  logic [cachePkg::dataWidth-1:0]   memWdata,
   output logic                             memRespValid,
   output logic [cachePkg::dataWidth-1:0]   memRdata
);

   // word store indexed by the byte address without its low bit
   logic [cachePkg::dataWidth-1:0] store [0:2**(cachePkg::addrWidth-1)-1];
   logic [cachePkg::addrWidth-2:0] readWord;
   int latency;

   initial begin
      // every word starts as its own word address mixed with a constant
      for (int i = 0; i < 2**(cachePkg::addrWidth-1); i++) begin
         store[i] = 16'(i) ^ 16'ha5c3;
      end
      memRespValid = 1'b0;
      memRdata = '0;
   end

   // strobes are sampled on the edge and answers are driven just after it
   always begin
      @(posedge clk);
      if (memWrite) begin
         store[memAddr[cachePkg::addrWidth-1:1]] = memWdata;
      end
      if (memRead) begin
         readWord = memAddr[cachePkg::addrWidth-1:1];
         // the answer is seen between one and four edges after the read
         latency = $urandom_range(4, 1);
         repeat (latency - 1) @(posedge clk);
         #1;
         memRespValid = 1'b1;
         memRdata = store[readWord];
         @(posedge clk);
         #1;
         memRespValid = 1'b0;
      end
   end

endmodule

`default_nettype wire

//--- testbench/cacheTb.sv
`timescale 1ns/10ps
`default_nettype none

module cacheTb;

   logic clk;
   logic rstN;
   logic reqValid;
   logic reqWrite;
   logic [cachePkg::addrWidth-1:0] reqAddr;
   logic [cachePkg::dataWidth-1:0] reqWdata;
   logic respValid;
   logic [cachePkg::dataWidth-1:0] respRdata;
   logic busy;
   logic memRead;
   logic memWrite;
   logic [cachePkg::addrWidth-1:0] memAddr;
   logic [cachePkg::dataWidth-1:0] memWdata;
   logic memRespValid;
   logic [cachePkg::dataWidth-1:0] memRdata;

   // reference copy of memory that every write also updates
   logic [cachePkg::dataWidth-1:0] model [0:2**(cachePkg::addrWidth-1)-1];

   // memory traffic seen during the current request
   logic [cachePkg::addrWidth-1:0] readAddrs[$];
   logic [31:0] writeLog[$];

   // protocol state kept by the monitor
   logic sawRequest = 1'b0;
   logic pending = 1'b0;
   logic outstanding = 1'b0;
   logic respLastEdge = 1'b0;
   int gap;

   initial clk = 1'b0;
   always #5 clk = ~clk;

   cacheTop i_dut (
      .clk(clk), .rstN(rstN),
      .reqValid(reqValid), .reqWrite(reqWrite), .reqAddr(reqAddr), .reqWdata(reqWdata),
      .respValid(respValid), .respRdata(respRdata), .busy(busy),
      .memRead(memRead), .memWrite(memWrite), .memAddr(memAddr), .memWdata(memWdata),
      .memRespValid(memRespValid), .memRdata(memRdata)
   );

   tbMemory i_mem (
      .clk(clk), .memRead(memRead), .memWrite(memWrite), .memAddr(memAddr),
      .memWdata(memWdata), .memRespValid(memRespValid), .memRdata(memRdata)
   );

   task automatic stopRun();
      $display("Finished with errors");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic failValue(input string msg);
      $display("FAIL at %0t: %s", $time, msg);
      stopRun();
   endtask

   task automatic failTimeout(input string what);
      $display("timed out at %0t while waiting for %s", $time, what);
      stopRun();
   endtask

   function automatic logic [cachePkg::addrWidth-1:0] makeAddr(input int tag, input int set,
                                                              input int word);
      return {6'(tag), 6'(set), 3'(word), 1'b0};
   endfunction

   // protocol checks on every edge once reset is released
   always @(posedge clk) begin
      if (rstN) begin
         if (!sawRequest) begin
            assert (!busy && !respValid && !memRead && !memWrite)
               else failValue("an output is active before the first request");
         end
         if (pending) begin
            assert (busy) else failValue("busy is low while a request is open");
         end
         assert (!respValid || pending) else failValue("respValid with no open request");
         // write-through strobe lands in the response cycle
         assert (!memWrite || respValid) else failValue("memWrite apart from respValid");
         assert (!(memRead && outstanding)) else failValue("memRead while a read is open");
         // a fill asks for the next word one cycle after each answer
         if (respLastEdge && readAddrs.size() < cachePkg::wordsPerBlock) begin
            assert (memRead) else failValue("memRead late after a memory answer");
         end
         respLastEdge = memRespValid && outstanding;
         if (memRespValid) outstanding = 1'b0;
         if (memRead) begin
            outstanding = 1'b1;
            readAddrs.push_back(memAddr);
         end
         if (memWrite) writeLog.push_back({memAddr, memWdata});
         if (respValid) pending = 1'b0;
         if (reqValid) begin
            pending = 1'b1;
            sawRequest = 1'b1;
         end
      end
   end

   // one request from idle to response
   // outcome 1 demands a hit, 2 a miss, 0 takes either
   task automatic access(input logic write, input logic [cachePkg::addrWidth-1:0] addr,
                         input logic [cachePkg::dataWidth-1:0] wdata, input int outcome);
      int waited;
      int edges;
      logic respSeen;
      logic [cachePkg::dataWidth-1:0] expected;
      logic [cachePkg::dataWidth-1:0] data;
      logic [cachePkg::addrWidth-1:0] base;
      waited = 0;
      while (busy) begin
         @(posedge clk);
         #1;
         waited++;
         if (busy && waited >= 50) failTimeout("busy to drop");
      end
      readAddrs.delete();
      writeLog.delete();
      reqValid = 1'b1;
      reqWrite = write;
      reqAddr = addr;
      reqWdata = wdata;
      if (write) model[addr[cachePkg::addrWidth-1:1]] = wdata;
      expected = model[addr[cachePkg::addrWidth-1:1]];
      @(posedge clk);
      #1;
      reqValid = 1'b0;
      edges = 0;
      respSeen = 1'b0;
      while (!respSeen) begin
         @(posedge clk);
         edges++;
         respSeen = respValid;
         if (!respSeen && edges >= 200) failTimeout("respValid");
      end
      data = respRdata;
      // let the monitor log this edge's traffic first
      #1;
      if (!write) begin
         assert (data == expected)
            else failValue($sformatf("read %h gave %h, expected %h", addr, data, expected));
         assert (writeLog.size() == 0) else failValue("memWrite during a read");
      end else begin
         assert (writeLog.size() == 1 && writeLog[0] == {addr & 16'hfffe, wdata})
            else failValue($sformatf("write %h did not reach memory once", addr));
      end
      assert (readAddrs.size() == 0 || (!write && readAddrs.size() == 8))
         else failValue($sformatf("%0d memRead strobes for %h", readAddrs.size(), addr));
      assert (outcome != 1 || readAddrs.size() == 0) else failValue("expected a hit");
      assert (outcome != 2 || readAddrs.size() == 8) else failValue("expected a miss");
      if (readAddrs.size() == 0) begin
         assert (edges == 2) else failValue($sformatf("hit took %0d edges", edges));
      end
      base = {addr[cachePkg::addrWidth-1:cachePkg::offsetWidth], 4'b0};
      foreach (readAddrs[i]) begin
         assert (readAddrs[i] == base + 16'(2 * i))
            else failValue($sformatf("fill read %0d went to %h", i, readAddrs[i]));
      end
   endtask

   initial begin
      void'($urandom(32'hedfb2287));
      for (int i = 0; i < 2**(cachePkg::addrWidth-1); i++) begin
         model[i] = 16'(i) ^ 16'ha5c3;
      end
      rstN = 1'b0;
      reqValid = 1'b0;
      reqWrite = 1'b0;
      reqAddr = '0;
      reqWdata = '0;
      repeat (16) @(posedge clk);
      #1;
      rstN = 1'b1;
      // a quiet stretch where every output must stay low
      repeat (4) begin
         @(posedge clk);
         #1;
      end
      // a cold block fills and then its other words hit
      access(1'b0, makeAddr(3, 5, 3), '0, 2);
      access(1'b0, makeAddr(3, 5, 0), '0, 1);
      access(1'b0, makeAddr(3, 5, 7), '0, 1);
      // a write hit is read back and a write miss is followed by a read that fills
      access(1'b1, makeAddr(3, 5, 2), 16'hbeef, 0);
      access(1'b0, makeAddr(3, 5, 2), '0, 1);
      access(1'b1, makeAddr(7, 9, 2), 16'h1234, 0);
      access(1'b0, makeAddr(7, 9, 2), '0, 2);
      // tags A B C share set 20 and C must push out B while A stays
      access(1'b0, makeAddr(1, 20, 0), '0, 2);
      access(1'b0, makeAddr(2, 20, 0), '0, 2);
      access(1'b0, makeAddr(1, 20, 1), '0, 1);
      access(1'b0, makeAddr(3, 20, 0), '0, 2);
      access(1'b0, makeAddr(1, 20, 2), '0, 1);
      access(1'b0, makeAddr(2, 20, 0), '0, 2);
      // mixed traffic over four sets and four tags so ways get evicted often
      for (int n = 0; n < 200; n++) begin
         gap = $urandom_range(2, 0);
         repeat (gap) begin
            @(posedge clk);
            #1;
         end
         access(1'($urandom_range(1, 0)),
                makeAddr($urandom_range(3, 0), $urandom_range(3, 0), $urandom_range(7, 0)),
                16'($urandom), 0);
      end
      $display("Finished with no errors");
      $finish;
   end

endmodule

`default_nettype wire

//--- tb.f
design/cachePkg.sv
design/metaDataArray.sv
design/dataArray.sv
design/cacheFillFsm.sv
design/cacheController.sv
design/cacheTop.sv
testbench/tbMemory.sv
testbench/cacheTb.sv
